// ==== hdl/parking_pkg.sv ====
package parking_pkg;

    // Card layout is {site code, user index}
    typedef logic [7:0] card_id_t;
    typedef logic [3:0] user_idx_t;

    // Free spaces left in one area
    typedef logic [2:0] count_t;

    typedef enum logic [1:0] {
        area_special0 = 2'd0,
        area_normal0  = 2'd1,
        area_floor1   = 2'd2
    } area_t;

    localparam logic [3:0] SITE_CODE = 4'hA;

    // Users 0 to 3 hold special cards
    localparam user_idx_t SPECIAL_USERS = 4'd4;

    localparam count_t CAP_SPECIAL0 = 3'd2;
    localparam count_t CAP_NORMAL0  = 3'd3;
    localparam count_t CAP_FLOOR1   = 3'd5;

endpackage

// ==== hdl/gate_pkg.sv ====
package gate_pkg;

    typedef enum logic [3:0] {
        st_off            = 4'd0,
        st_idle           = 4'd1,
        st_check          = 4'd2,
        st_granted_chosen = 4'd3,
        st_granted_alt    = 4'd4,
        st_no_space       = 4'd5,
        st_incorrect      = 4'd6,
        st_exit_ok        = 4'd7,
        st_exit_incorrect = 4'd8
    } gate_state_t;

    // Message codes for the display driver
    typedef enum logic [3:0] {
        msg_blank     = 4'd0,
        msg_welcome   = 4'd1,
        msg_granted   = 4'd2,
        msg_incorrect = 4'd3,
        msg_no_space  = 4'd4,
        msg_goodbye   = 4'd5
    } display_msg_t;

    typedef logic [2:0] sec_t;

    // Result hold times in seconds
    localparam sec_t HOLD_GRANT = 3'd3;
    localparam sec_t HOLD_ERROR = 3'd5;

endpackage

// ==== hdl/second_timer.sv ====
`timescale 1ns/10ps

module second_timer
    import gate_pkg::*;
#(
    parameter int TICKS_PER_SEC = 50_000_000
) (
    input  logic clk,
    input  logic rst_n,
    input  logic clear,
    output sec_t seconds
);

    localparam int PW = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
    localparam logic [PW-1:0] LAST_TICK = PW'(TICKS_PER_SEC - 1);

    logic [PW-1:0] prescale;

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            prescale <= '0;
            seconds  <= '0;
        end else if (prescale == LAST_TICK) begin
            prescale <= '0;
            // Saturate so long holds never wrap
            if (seconds != '1) begin
                seconds <= seconds + 1'b1;
            end
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

endmodule

// ==== hdl/user_registry.sv ====
`timescale 1ns/10ps

module user_registry
    import parking_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  card_id_t card_id,
    input  logic     card_take,
    input  logic     park,
    input  area_t    park_area,
    input  logic     leave,
    output logic     id_valid,
    output logic     id_special,
    output logic     id_parked,
    output area_t    parked_area
);

    card_id_t  card_q;
    user_idx_t user_idx;
    logic [15:0] parked;
    area_t     area_mem [0:15];

    always_ff @(posedge clk) begin
        if (card_take) begin
            card_q <= card_id;
        end
    end

    assign user_idx   = user_idx_t'(card_q[3:0]);
    assign id_valid   = (card_q[7:4] == SITE_CODE);
    assign id_special = (user_idx < SPECIAL_USERS);

    // One parked flag per user index
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            parked <= '0;
        end else if (park) begin
            parked[user_idx] <= 1'b1;
        end else if (leave) begin
            parked[user_idx] <= 1'b0;
        end
    end

    // Area only matters while the parked flag is set
    always_ff @(posedge clk) begin
        if (park) begin
            area_mem[user_idx] <= park_area;
        end
    end

    assign id_parked   = parked[user_idx];
    assign parked_area = area_mem[user_idx];

endmodule

// ==== hdl/space_counter.sv ====
`timescale 1ns/10ps

module space_counter
    import parking_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   park,
    input  area_t  park_area,
    input  logic   leave,
    input  area_t  parked_area,
    output count_t remain_special0,
    output count_t remain_normal0,
    output count_t remain_floor1,
    output logic   special0_full,
    output logic   normal0_full,
    output logic   floor1_full
);

    // Indexed by area_t encoding
    localparam count_t CAPS [0:2] = '{CAP_SPECIAL0, CAP_NORMAL0, CAP_FLOOR1};

    count_t remain [0:2];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            if (!rst_n) begin
                remain[i] <= CAPS[i];
            end else if (park && (park_area == area_t'(i))) begin
                remain[i] <= remain[i] - 1'b1;
            end else if (leave && (parked_area == area_t'(i))) begin
                remain[i] <= remain[i] + 1'b1;
            end
        end
    end

    assign remain_special0 = remain[0];
    assign remain_normal0  = remain[1];
    assign remain_floor1   = remain[2];

    assign special0_full = (remain[0] == '0);
    assign normal0_full  = (remain[1] == '0);
    assign floor1_full   = (remain[2] == '0);

endmodule

// ==== hdl/gate_fsm.sv ====
`timescale 1ns/10ps

module gate_fsm
    import parking_pkg::*;
    import gate_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         power,
    input  logic         card_strobe,
    input  logic         floor_sel,
    input  logic         exit_req,
    input  sec_t         seconds,
    input  logic         id_valid,
    input  logic         id_special,
    input  logic         id_parked,
    input  logic         special0_full,
    input  logic         normal0_full,
    input  logic         floor1_full,
    output logic         card_take,
    output logic         timer_clear,
    output logic         park,
    output area_t        park_area,
    output logic         leave,
    output logic         power_led,
    output logic         green_led,
    output logic         red_wrong_led,
    output display_msg_t display_msg
);

    gate_state_t state;
    gate_state_t next_state;
    logic        exit_q;
    logic        floor_q;
    logic        chosen_full;
    logic        alt_full;
    area_t       chosen_area;
    area_t       alt_area;
    sec_t        hold_time;

    assign card_take   = power && card_strobe && (state == st_idle);
    assign timer_clear = (state == st_off) || (state == st_idle) || (state == st_check);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_off;
            exit_q  <= 1'b0;
            floor_q <= 1'b0;
        end else begin
            state <= next_state;
            if (card_take) begin
                exit_q  <= exit_req;
                floor_q <= floor_sel;
            end
        end
    end

    assign chosen_area = floor_q ? area_floor1 : area_normal0;
    assign alt_area    = floor_q ? area_normal0 : area_floor1;
    assign chosen_full = floor_q ? floor1_full : normal0_full;
    assign alt_full    = floor_q ? normal0_full : floor1_full;

    assign hold_time = ((state == st_incorrect) || (state == st_exit_incorrect)) ?
                       HOLD_ERROR : HOLD_GRANT;

    always_comb begin
        next_state = state;
        park       = 1'b0;
        leave      = 1'b0;
        park_area  = chosen_area;
        unique case (state)
            st_off: begin
                next_state = st_idle;
            end
            st_idle: begin
                if (card_strobe) begin
                    next_state = st_check;
                end
            end
            st_check: begin
                if (exit_q) begin
                    if (id_valid && id_parked) begin
                        next_state = st_exit_ok;
                        leave      = 1'b1;
                    end else begin
                        next_state = st_exit_incorrect;
                    end
                end else if (!id_valid || id_parked) begin
                    next_state = st_incorrect;
                end else if (id_special) begin
                    // Special cards never spill onto the normal floors
                    park_area  = area_special0;
                    park       = !special0_full;
                    next_state = special0_full ? st_no_space : st_granted_chosen;
                end else if (!chosen_full) begin
                    park       = 1'b1;
                    next_state = st_granted_chosen;
                end else if (!alt_full) begin
                    park_area  = alt_area;
                    park       = 1'b1;
                    next_state = st_granted_alt;
                end else begin
                    next_state = st_no_space;
                end
            end
            st_granted_chosen, st_granted_alt, st_no_space,
            st_exit_ok, st_incorrect, st_exit_incorrect: begin
                if (seconds >= hold_time) begin
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_off;
            end
        endcase
        // Power loss wins over everything and leaves counts untouched
        if (!power) begin
            next_state = st_off;
            park       = 1'b0;
            leave      = 1'b0;
        end
    end

    always_comb begin
        power_led     = 1'b1;
        green_led     = 1'b0;
        red_wrong_led = 1'b0;
        display_msg   = msg_welcome;
        unique case (state)
            st_off: begin
                power_led   = 1'b0;
                display_msg = msg_blank;
            end
            st_granted_chosen, st_granted_alt: begin
                green_led   = 1'b1;
                display_msg = msg_granted;
            end
            st_no_space: begin
                display_msg = msg_no_space;
            end
            st_incorrect, st_exit_incorrect: begin
                red_wrong_led = 1'b1;
                display_msg   = msg_incorrect;
            end
            st_exit_ok: begin
                green_led   = 1'b1;
                display_msg = msg_goodbye;
            end
            default: begin
                display_msg = msg_welcome;
            end
        endcase
    end

endmodule

// ==== hdl/parking_top.sv ====
`timescale 1ns/10ps

module parking_top
    import parking_pkg::*;
    import gate_pkg::*;
#(
    parameter int TICKS_PER_SEC = 50_000_000
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         power,
    input  card_id_t     card_id,
    input  logic         card_strobe,
    input  logic         floor_sel,
    input  logic         exit_req,
    output logic         power_led,
    output logic         green_led,
    output logic         red_wrong_led,
    output display_msg_t display_msg,
    output count_t       remain_special0,
    output count_t       remain_normal0,
    output count_t       remain_floor1
);

    logic  card_take;
    logic  timer_clear;
    logic  park;
    logic  leave;
    area_t park_area;
    area_t parked_area;
    sec_t  seconds;
    logic  id_valid;
    logic  id_special;
    logic  id_parked;
    logic  special0_full;
    logic  normal0_full;
    logic  floor1_full;

    second_timer #(
        .TICKS_PER_SEC(TICKS_PER_SEC)
    ) second_timer_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (timer_clear),
        .seconds(seconds)
    );

    user_registry user_registry_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .card_id    (card_id),
        .card_take  (card_take),
        .park       (park),
        .park_area  (park_area),
        .leave      (leave),
        .id_valid   (id_valid),
        .id_special (id_special),
        .id_parked  (id_parked),
        .parked_area(parked_area)
    );

    space_counter space_counter_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .park           (park),
        .park_area      (park_area),
        .leave          (leave),
        .parked_area    (parked_area),
        .remain_special0(remain_special0),
        .remain_normal0 (remain_normal0),
        .remain_floor1  (remain_floor1),
        .special0_full  (special0_full),
        .normal0_full   (normal0_full),
        .floor1_full    (floor1_full)
    );

    gate_fsm gate_fsm_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .power        (power),
        .card_strobe  (card_strobe),
        .floor_sel    (floor_sel),
        .exit_req     (exit_req),
        .seconds      (seconds),
        .id_valid     (id_valid),
        .id_special   (id_special),
        .id_parked    (id_parked),
        .special0_full(special0_full),
        .normal0_full (normal0_full),
        .floor1_full  (floor1_full),
        .card_take    (card_take),
        .timer_clear  (timer_clear),
        .park         (park),
        .park_area    (park_area),
        .leave        (leave),
        .power_led    (power_led),
        .green_led    (green_led),
        .red_wrong_led(red_wrong_led),
        .display_msg  (display_msg)
    );

endmodule

// ==== tests/parking_sva.sv ====
`timescale 1ns/10ps

module parking_sva
    import gate_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input gate_state_t state,
    input logic        park,
    input logic        leave,
    input logic        green_led,
    input logic        red_wrong_led
);

    int fail_count = 0;

    park_leave_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(park && leave))
        else begin
            $error("park and leave high in the same cycle");
            fail_count++;
        end

    // Registry and counters only move in the first cycle of st_check
    update_after_check: assert property (@(posedge clk) disable iff (!rst_n)
        (park || leave) |-> ((state == st_check) && ($past(state) == st_idle)))
        else begin
            $error("park or leave outside the cycle after st_check was entered");
            fail_count++;
        end

    leds_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(green_led && red_wrong_led))
        else begin
            $error("green and red LEDs lit together");
            fail_count++;
        end

endmodule

bind gate_fsm parking_sva gate_sva_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .state        (state),
    .park         (park),
    .leave        (leave),
    .green_led    (green_led),
    .red_wrong_led(red_wrong_led)
);

// ==== tests/parking_tb.sv ====
`timescale 1ns/10ps

module parking_tb
    import parking_pkg::*;
    import gate_pkg::*;
;

    localparam int CYCLE_LIMIT = 1500;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         power;
    card_id_t     card_id;
    logic         card_strobe;
    logic         floor_sel;
    logic         exit_req;
    logic         power_led;
    logic         green_led;
    logic         red_wrong_led;
    display_msg_t display_msg;
    count_t       remain_special0;
    count_t       remain_normal0;
    count_t       remain_floor1;

    // Reference model counts use the area_t encoding as index
    int          m_count [0:2];
    logic        m_parked [0:15];
    int          m_area [0:15];
    logic [31:0] rng = 32'h4178;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          err_mark = 0;
    int          tests = 0;
    int          passed = 0;

    parking_top #(
        .TICKS_PER_SEC(4)
    ) parking_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .power          (power),
        .card_id        (card_id),
        .card_strobe    (card_strobe),
        .floor_sel      (floor_sel),
        .exit_req       (exit_req),
        .power_led      (power_led),
        .green_led      (green_led),
        .red_wrong_led  (red_wrong_led),
        .display_msg    (display_msg),
        .remain_special0(remain_special0),
        .remain_normal0 (remain_normal0),
        .remain_floor1  (remain_floor1)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Predicts the message and updates the model like the gate would
    function automatic display_msg_t predict_result(input logic [3:0] site,
                                                    input logic [3:0] user,
                                                    input logic floor,
                                                    input logic ext);
        int take;
        int chosen;
        int alt;
        take   = -1;
        chosen = floor ? 2 : 1;
        alt    = floor ? 1 : 2;
        if (ext) begin
            if (site == 4'hA && m_parked[user]) begin
                m_count[m_area[user]]++;
                m_parked[user] = 1'b0;
                return msg_goodbye;
            end
            return msg_incorrect;
        end
        if (site != 4'hA || m_parked[user]) begin
            return msg_incorrect;
        end
        if (user < 4'd4) begin
            take = (m_count[0] > 0) ? 0 : -1;
        end else if (m_count[chosen] > 0) begin
            take = chosen;
        end else if (m_count[alt] > 0) begin
            take = alt;
        end
        if (take < 0) begin
            return msg_no_space;
        end
        m_count[take]--;
        m_parked[user] = 1'b1;
        m_area[user]   = take;
        return msg_granted;
    endfunction

    task automatic check_val(input string name, input int exp, input int act);
        checks++;
        assert (exp == act) else begin
            $display("error %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_counts(input string name);
        check_val({name, " special0"}, m_count[0], int'(remain_special0));
        check_val({name, " normal0"}, m_count[1], int'(remain_normal0));
        check_val({name, " floor1"}, m_count[2], int'(remain_floor1));
    endtask

    // LED pattern that goes with each message
    task automatic compare_leds(input string name, input display_msg_t msg);
        logic exp_power;
        logic exp_green;
        logic exp_red;
        exp_power = (msg != msg_blank);
        exp_green = (msg == msg_granted) || (msg == msg_goodbye);
        exp_red   = (msg == msg_incorrect);
        check_val({name, " power_led"}, int'(exp_power), int'(power_led));
        check_val({name, " green_led"}, int'(exp_green), int'(green_led));
        check_val({name, " red_wrong_led"}, int'(exp_red), int'(red_wrong_led));
    endtask

    task automatic send_card(input card_id_t card, input logic floor, input logic ext);
        @(posedge clk);
        card_id     <= card;
        floor_sel   <= floor;
        exit_req    <= ext;
        card_strobe <= 1'b1;
        @(posedge clk);
        card_strobe <= 1'b0;
    endtask

    task automatic wait_welcome();
        @(negedge clk);
        while (display_msg != msg_welcome) begin
            @(negedge clk);
        end
    endtask

    // Result state is entered one edge after the card is taken
    task automatic request(input string name, input logic [3:0] site, input logic [3:0] user,
                           input logic floor, input logic ext);
        display_msg_t exp_msg;
        exp_msg = predict_result(site, user, floor, ext);
        send_card({site, user}, floor, ext);
        @(posedge clk);
        @(negedge clk);
        check_val({name, " msg"}, int'(exp_msg), int'(display_msg));
        compare_leds(name, exp_msg);
        check_counts(name);
        wait_welcome();
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        display_msg_t exp_msg;
        logic [3:0]   special;
        rst_n       = 1'b0;
        power       = 1'b0;
        card_id     = '0;
        card_strobe = 1'b0;
        floor_sel   = 1'b0;
        exit_req    = 1'b0;
        m_count[0]  = 2;
        m_count[1]  = 3;
        m_count[2]  = 5;
        for (int i = 0; i < 16; i++) begin
            m_parked[i] = 1'b0;
            m_area[i]   = 0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        @(posedge clk);
        @(negedge clk);
        check_val("power_up msg", int'(msg_blank), int'(display_msg));
        compare_leds("power_up", msg_blank);
        check_counts("power_up");
        @(posedge clk);
        power <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_val("power_up on msg", int'(msg_welcome), int'(display_msg));
        compare_leds("power_up on", msg_welcome);
        end_test("power_up");

        request("chosen_floor", 4'hA, 4'd5, 1'b0, 1'b0);
        end_test("chosen_floor");

        request("fill_floor0", 4'hA, 4'd6, 1'b0, 1'b0);
        request("fill_floor0", 4'hA, 4'd7, 1'b0, 1'b0);
        request("alt_floor", 4'hA, 4'd8, 1'b0, 1'b0);
        for (int u = 9; u <= 12; u++) begin
            rng = xorshift(rng);
            request("fill_floor1", 4'hA, 4'(u), rng[0], 1'b0);
        end
        rng = xorshift(rng);
        request("no_space", 4'hA, 4'd13, rng[0], 1'b0);
        end_test("overflow");

        request("wrong_site", 4'h3, 4'd5, 1'b0, 1'b0);
        request("double_entry", 4'hA, 4'd5, 1'b0, 1'b0);
        end_test("incorrect");

        rng     = xorshift(rng);
        special = {2'b00, rng[1:0]};
        request("special_entry", 4'hA, special, rng[2], 1'b0);
        request("special_exit", 4'hA, special, 1'b0, 1'b1);
        request("exit_not_parked", 4'hA, special, 1'b0, 1'b1);
        request("floor1_exit", 4'hA, 4'd8, 1'b0, 1'b1);
        end_test("special_and_exit");

        // Second card arrives while the grant is still on display
        exp_msg = predict_result(4'hA, special, 1'b0, 1'b0);
        send_card({4'hA, special}, 1'b0, 1'b0);
        @(posedge clk);
        @(negedge clk);
        check_val("busy_strobe msg", int'(exp_msg), int'(display_msg));
        compare_leds("busy_strobe", exp_msg);
        send_card({4'hA, 4'd14}, 1'b1, 1'b0);
        @(negedge clk);
        check_val("busy_strobe held msg", int'(exp_msg), int'(display_msg));
        compare_leds("busy_strobe held", exp_msg);
        check_counts("busy_strobe");
        @(posedge clk);
        power <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_val("power_off msg", int'(msg_blank), int'(display_msg));
        compare_leds("power_off", msg_blank);
        check_counts("power_off");
        @(posedge clk);
        power <= 1'b1;
        wait_welcome();
        check_counts("power_on");
        end_test("busy_and_power");

        errors += parking_top_inst.gate_fsm_inst.gate_sva_inst.fail_count;
        $display("summary: %0d tests, %0d ok, %0d checks, %0d errors",
                 tests, passed, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
hdl/parking_pkg.sv
hdl/gate_pkg.sv
hdl/second_timer.sv
hdl/user_registry.sv
hdl/space_counter.sv
hdl/gate_fsm.sv
hdl/parking_top.sv
tests/parking_sva.sv
tests/parking_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := parking_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
RUN_ARGS  := +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
